/* sources.f */
+incdir+.
mh_pkg.sv
mh_resp_if.sv
mh_fifo.sv
mh_miss_request.sv
mh_mshr.sv
mh_resp_decode.sv
mh_refill_execute.sv
miss_handler_top.sv
tb_miss_handler.sv

/* Bender.yml */
package:
  name: miss_handler

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mh_pkg.sv
      - mh_resp_if.sv
      - mh_fifo.sv
      - mh_miss_request.sv
      - mh_mshr.sv
      - mh_resp_decode.sv
      - mh_refill_execute.sv
      - miss_handler_top.sv
  - target: test
    files:
      - tb_miss_handler.sv

/* tb_miss_handler.sv */
`timescale 1ns/100ps

module tb_miss_handler
    import mh_pkg::*;
();

    localparam int unsigned CLK_PERIOD      = 100;
    localparam int unsigned SETTLE          = 40;
    localparam int unsigned NUM_TESTS       = 5;
    localparam int unsigned CYCLES_PER_TEST = 200;
    localparam int unsigned WAIT_LIMIT      = 150;

    logic         clk_i;
    logic         rst_ni;
    logic         mshr_empty_o;
    logic         mshr_full_o;
    logic         mshr_check_i;
    mh_nline_t    mshr_check_nline_i;
    logic         mshr_check_hit_o;
    logic         mshr_alloc_i;
    mh_nline_t    mshr_alloc_nline_i;
    mh_tid_t      mshr_alloc_tid_i;
    mh_word_idx_t mshr_alloc_word_i;
    logic         mshr_alloc_need_rsp_i;
    logic         mshr_alloc_ready_o;
    logic         mshr_alloc_full_o;
    logic         refill_req_ready_i;
    logic         refill_req_valid_o;
    logic         refill_busy_o;
    logic         refill_write_data_o;
    logic         refill_write_dir_o;
    mh_set_t      refill_set_o;
    mh_word_idx_t refill_word_o;
    mh_word_t     refill_data_o;
    mh_nline_t    refill_nline_o;
    logic         core_rsp_valid_o;
    mh_word_t     core_rsp_data_o;
    mh_tid_t      core_rsp_tid_o;
    logic         core_rsp_error_o;
    logic         mem_req_ready_i;
    logic         mem_req_valid_o;
    mh_addr_t     mem_req_addr_o;
    mh_mshr_idx_t mem_req_id_o;
    logic         mem_resp_valid_i;
    logic         mem_resp_last_i;
    logic         mem_resp_error_i;
    mh_mshr_idx_t mem_resp_id_i;
    mh_word_t     mem_resp_data_i;
    logic         mem_resp_ready_o;

    integer       seed = 32'hdba2;
    int unsigned  err_count;
    int unsigned  test_errs;
    int unsigned  test_num;
    int unsigned  failed_tests;
    int unsigned  outstanding;

    // Expected state per MSHR index
    logic         exp_valid [4];
    mh_nline_t    exp_line  [4];
    mh_tid_t      exp_tid   [4];
    mh_word_idx_t exp_word  [4];
    logic         exp_err   [4];
    int unsigned  wr_cnt    [4];
    logic         dir_seen  [4];
    logic         rsp_seen  [4];

    // Write cycles left in the current refill, and a core response due next cycle
    int unsigned  busy_left;
    logic         rsp_due;

    // Memory model state
    mh_nline_t    req_line_q [$];
    mh_nline_t    pend_line  [$];
    logic         hold_resp;
    logic [3:0]   err_idx;
    logic         sending;
    mh_nline_t    cur_line;
    int unsigned  beat;

    miss_handler_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Memory contents are a fixed mix of line address and word position
    function automatic mh_word_t ref_word(input mh_nline_t line, input mh_word_idx_t word);
        ref_word = (mh_word_t'(line) * 32'h9e37_79b1) ^ (32'h0101_0101 * (mh_word_t'(word) + 1));
    endfunction

    function automatic mh_core_rsp_t ref_rsp(input mh_mshr_idx_t idx);
        ref_rsp = '{data: ref_word(exp_line[idx], exp_word[idx]), tid: exp_tid[idx],
                    error: exp_err[idx]};
    endfunction

    task automatic check_word(input string what, input mh_word_t got, input mh_word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_nline(input string what, input mh_nline_t got, input mh_nline_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is line %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_set(input string what, input mh_set_t got, input mh_set_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is set %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_rsp(input string what, input mh_core_rsp_t got, input mh_core_rsp_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is data %h tid %h err %b, expected %h %h %b", $time,
                     what, got.data, got.tid, got.error, exp.data, exp.tid, exp.error);
            err_count++;
        end
    endtask

    task automatic check_idx(input string what, input mh_mshr_idx_t got, input mh_mshr_idx_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic alloc_miss(input mh_nline_t line, input logic [1:0] tid_hi,
                              input mh_word_idx_t word);
        mh_mshr_idx_t idx;
        int unsigned  waited;
        idx    = mh_mshr_idx_t'(line);
        waited = 0;
        @(negedge clk_i);
        mshr_alloc_i          = 1'b1;
        mshr_alloc_nline_i    = line;
        mshr_alloc_tid_i      = {tid_hi, idx};
        mshr_alloc_word_i     = word;
        mshr_alloc_need_rsp_i = 1'b1;
        #SETTLE;
        while (!mshr_alloc_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            #SETTLE;
            waited++;
        end
        if (!mshr_alloc_ready_o) begin
            $display("Miss for line %h was never accepted (at %0t)", line, $time);
            err_count++;
        end else begin
            check_flag("alloc_full before allocation", mshr_alloc_full_o, 1'b0);
            exp_line[idx]  = line;
            exp_tid[idx]   = {tid_hi, idx};
            exp_word[idx]  = word;
            exp_err[idx]   = err_idx[idx];
            wr_cnt[idx]    = 0;
            dir_seen[idx]  = 1'b0;
            rsp_seen[idx]  = 1'b0;
            exp_valid[idx] = 1'b1;
            outstanding++;
            req_line_q.push_back(line);
        end
        @(negedge clk_i);
        mshr_alloc_i = 1'b0;
    endtask

    task automatic wait_done(input string what);
        int unsigned waited;
        waited = 0;
        @(negedge clk_i);
        while ((outstanding != 0 || busy_left != 0) && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (outstanding != 0 || busy_left != 0) begin
            $display("%s did not complete within %0d cycles (at %0t)", what, WAIT_LIMIT, $time);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (err_count == test_errs) begin
            $display("Test %0d %s: PASS", test_num, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAIL with %0d errors", test_num, name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    // Memory model that takes requests and returns whole lines in random order
    always @(negedge clk_i) begin : mem_model
        int unsigned pick;
        mh_nline_t   req_line;
        mem_req_ready_i    = $random(seed) & 1;
        refill_req_ready_i = ($unsigned($random(seed)) % 4) != 0;
        if (!sending && !hold_resp && pend_line.size() != 0) begin
            pick     = $unsigned($random(seed)) % pend_line.size();
            cur_line = pend_line[pick];
            pend_line.delete(pick);
            beat     = 0;
            sending  = 1'b1;
        end
        mem_resp_valid_i = sending;
        mem_resp_last_i  = sending && (beat == 3);
        mem_resp_id_i    = mh_mshr_idx_t'(cur_line);
        mem_resp_error_i = sending && err_idx[mh_mshr_idx_t'(cur_line)];
        mem_resp_data_i  = sending ? ref_word(cur_line, mh_word_idx_t'(beat)) : '0;
        #SETTLE;
        if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            if (req_line_q.size() == 0) begin
                $display("Memory request with no miss outstanding (at %0t)", $time);
                err_count++;
            end else begin
                req_line = req_line_q.pop_front();
                check_word("memory request address", mh_word_t'(mem_req_addr_o),
                           mh_word_t'(req_line) << 4);
                check_idx("memory request id", mem_req_id_o, mh_mshr_idx_t'(req_line));
                pend_line.push_back(mh_nline_t'(mem_req_addr_o >> 4));
            end
        end
        if (rst_ni && mem_resp_valid_i && mem_resp_ready_o) begin
            beat++;
            if (beat == 4) begin
                sending = 1'b0;
            end
        end
    end

    // Compares refill writes and core responses with the expected entries
    always @(negedge clk_i) begin : compare
        mh_mshr_idx_t idx;
        int unsigned  pos;
        #SETTLE;
        if (rst_ni) begin
            // A grant is followed by four write cycles, the response trails its word by one
            check_flag("core response timing", core_rsp_valid_o, rsp_due);
            check_flag("refill busy", refill_busy_o, busy_left != 0);
            rsp_due = 1'b0;
            if (busy_left != 0) begin
                idx     = mh_mshr_idx_t'(refill_nline_o);
                pos     = 4 - busy_left;
                rsp_due = exp_valid[idx] && (mh_word_idx_t'(pos) == exp_word[idx]);
                busy_left--;
            end
            if (refill_req_valid_o && refill_req_ready_i) begin
                busy_left = 4;
            end
        end
        if (rst_ni && refill_write_data_o) begin
            idx = mh_mshr_idx_t'(refill_nline_o);
            if (!exp_valid[idx] || exp_err[idx]) begin
                $display("Unexpected data write for line %h (at %0t)", refill_nline_o, $time);
                err_count++;
            end else begin
                check_nline("refill line", refill_nline_o, exp_line[idx]);
                check_set("refill set", refill_set_o, mh_set_t'(exp_line[idx]));
                check_word("refill word index", mh_word_t'(refill_word_o), wr_cnt[idx]);
                check_word("refill data", refill_data_o,
                           ref_word(exp_line[idx], mh_word_idx_t'(wr_cnt[idx])));
                wr_cnt[idx]++;
            end
        end
        if (rst_ni && refill_write_dir_o) begin
            idx = mh_mshr_idx_t'(refill_nline_o);
            if (!exp_valid[idx] || exp_err[idx]) begin
                $display("Unexpected directory write for line %h (at %0t)", refill_nline_o, $time);
                err_count++;
            end else begin
                check_nline("directory line", refill_nline_o, exp_line[idx]);
                check_word("data writes before directory write", wr_cnt[idx], 4);
                dir_seen[idx] = 1'b1;
            end
        end
        if (rst_ni && core_rsp_valid_o) begin
            idx = mh_mshr_idx_t'(core_rsp_tid_o);
            if (!exp_valid[idx] || rsp_seen[idx]) begin
                $display("Unexpected core response for tid %h (at %0t)", core_rsp_tid_o, $time);
                err_count++;
            end else begin
                check_rsp("core response", mh_core_rsp_t'{data: core_rsp_data_o,
                          tid: core_rsp_tid_o, error: core_rsp_error_o}, ref_rsp(idx));
                rsp_seen[idx] = 1'b1;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (exp_valid[i] && rsp_seen[i] && (exp_err[i] || dir_seen[i])) begin
                exp_valid[i] = 1'b0;
                outstanding--;
            end
        end
    end

    // Watchdog
    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + 10) * CLK_PERIOD);
        $display("Run stopped by the watchdog after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        clk_i                 = 1'b0;
        rst_ni                = 1'b0;
        mshr_check_i          = 1'b0;
        mshr_check_nline_i    = '0;
        mshr_alloc_i          = 1'b0;
        mshr_alloc_nline_i    = '0;
        mshr_alloc_tid_i      = '0;
        mshr_alloc_word_i     = '0;
        mshr_alloc_need_rsp_i = 1'b0;
        refill_req_ready_i    = 1'b0;
        mem_req_ready_i       = 1'b0;
        mem_resp_valid_i      = 1'b0;
        mem_resp_last_i       = 1'b0;
        mem_resp_error_i      = 1'b0;
        mem_resp_id_i         = '0;
        mem_resp_data_i       = '0;
        hold_resp             = 1'b0;
        err_idx               = '0;
        sending               = 1'b0;
        cur_line              = '0;
        beat                  = 0;
        err_count             = 0;
        test_errs             = 0;
        test_num              = 0;
        failed_tests          = 0;
        outstanding           = 0;
        busy_left             = 0;
        rsp_due               = 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_valid[i] = 1'b0;
        end
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;

        @(negedge clk_i);
        #SETTLE;
        check_flag("mem_req_valid after reset", mem_req_valid_o, 1'b0);
        check_flag("refill_req_valid after reset", refill_req_valid_o, 1'b0);
        check_flag("refill_write_data after reset", refill_write_data_o, 1'b0);
        check_flag("refill_write_dir after reset", refill_write_dir_o, 1'b0);
        check_flag("refill_busy after reset", refill_busy_o, 1'b0);
        check_flag("core_rsp_valid after reset", core_rsp_valid_o, 1'b0);
        check_flag("mshr_empty after reset", mshr_empty_o, 1'b1);
        check_flag("mshr_full after reset", mshr_full_o, 1'b0);
        end_test("reset state");

        alloc_miss(26'h2b5_93e, 2'd1, 2'd2);
        wait_done("single miss");
        end_test("single miss");

        // Responses are held back so that all four misses are pending at once
        @(posedge clk_i);
        hold_resp = 1'b1;
        for (int i = 0; i < 4; i++) begin
            alloc_miss(26'h0c3_a100 + i, 2'(i), mh_word_idx_t'(3 - i));
        end
        #SETTLE;
        check_flag("mshr_full with four pending", mshr_full_o, 1'b1);
        check_flag("mshr_empty with four pending", mshr_empty_o, 1'b0);
        @(posedge clk_i);
        hold_resp = 1'b0;
        wait_done("four misses");
        end_test("four misses out of order");

        @(posedge clk_i);
        err_idx[1] = 1'b1;
        alloc_miss(26'h1f0_0071, 2'd3, 2'd3);
        wait_done("error response");
        @(posedge clk_i);
        err_idx[1] = 1'b0;
        end_test("error response");

        @(posedge clk_i);
        hold_resp = 1'b1;
        alloc_miss(26'h0a5_5552, 2'd2, 2'd0);
        mshr_check_i       = 1'b1;
        mshr_check_nline_i = 26'h0a5_5552;
        #SETTLE;
        check_flag("check of the pending line", mshr_check_hit_o, 1'b1);
        @(negedge clk_i);
        mshr_check_nline_i = 26'h0a5_5552 ^ 26'h400;
        #SETTLE;
        check_flag("check of another line", mshr_check_hit_o, 1'b0);
        @(negedge clk_i);
        mshr_check_i       = 1'b0;
        mshr_alloc_nline_i = 26'h0a5_5552 ^ 26'h10_0000;
        #SETTLE;
        check_flag("alloc_full for the same index", mshr_alloc_full_o, 1'b1);
        @(posedge clk_i);
        hold_resp = 1'b0;
        wait_done("pending line check");
        #SETTLE;
        check_flag("mshr_empty after refill", mshr_empty_o, 1'b1);
        end_test("pending line check");

        $display("%0d tests run, %0d failed, %0d errors", test_num, failed_tests, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* miss_handler_top.sv */
`timescale 1ns/100ps

`include "mh_params.svh"

module miss_handler_top
    import mh_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    output logic         mshr_empty_o,
    output logic         mshr_full_o,

    input  logic         mshr_check_i,
    input  mh_nline_t    mshr_check_nline_i,
    output logic         mshr_check_hit_o,

    input  logic         mshr_alloc_i,
    input  mh_nline_t    mshr_alloc_nline_i,
    input  mh_tid_t      mshr_alloc_tid_i,
    input  mh_word_idx_t mshr_alloc_word_i,
    input  logic         mshr_alloc_need_rsp_i,
    output logic         mshr_alloc_ready_o,
    output logic         mshr_alloc_full_o,

    input  logic         refill_req_ready_i,
    output logic         refill_req_valid_o,
    output logic         refill_busy_o,
    output logic         refill_write_data_o,
    output logic         refill_write_dir_o,
    output mh_set_t      refill_set_o,
    output mh_word_idx_t refill_word_o,
    output mh_word_t     refill_data_o,
    output mh_nline_t    refill_nline_o,

    output logic         core_rsp_valid_o,
    output mh_word_t     core_rsp_data_o,
    output mh_tid_t      core_rsp_tid_o,
    output logic         core_rsp_error_o,

    input  logic         mem_req_ready_i,
    output logic         mem_req_valid_o,
    output mh_addr_t     mem_req_addr_o,
    output mh_mshr_idx_t mem_req_id_o,

    input  logic         mem_resp_valid_i,
    input  logic         mem_resp_last_i,
    input  logic         mem_resp_error_i,
    input  mh_mshr_idx_t mem_resp_id_i,
    input  mh_word_t     mem_resp_data_i,
    output logic         mem_resp_ready_o
);

    logic           mshr_alloc;
    mh_mshr_entry_t mshr_alloc_entry;
    logic           mshr_ack;
    mh_mshr_idx_t   mshr_ack_idx;
    mh_mshr_entry_t mshr_ack_entry;
    logic           mshr_empty;
    mh_core_rsp_t   core_rsp;

    mh_resp_if resp_if ();

    assign mshr_alloc_entry = '{
        tag:      mshr_alloc_nline_i[`MH_NLINE_W-1:6],
        set:      mshr_alloc_nline_i[5:0],
        tid:      mshr_alloc_tid_i,
        word:     mshr_alloc_word_i,
        need_rsp: mshr_alloc_need_rsp_i
    };

    // No miss is pending once the table is empty and the last refill is done
    assign mshr_empty_o = mshr_empty & ~refill_busy_o;

    assign core_rsp_data_o  = core_rsp.data;
    assign core_rsp_tid_o   = core_rsp.tid;
    assign core_rsp_error_o = core_rsp.error;

    mh_miss_request i_miss_request (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .mshr_alloc_i       (mshr_alloc_i),
        .mshr_alloc_nline_i (mshr_alloc_nline_i),
        .mshr_alloc_ready_o (mshr_alloc_ready_o),
        .alloc_o            (mshr_alloc),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_id_o       (mem_req_id_o)
    );

    mh_mshr i_mshr (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (mshr_alloc),
        .alloc_entry_i (mshr_alloc_entry),
        .alloc_full_o  (mshr_alloc_full_o),
        .check_i       (mshr_check_i),
        .check_nline_i (mshr_check_nline_i),
        .check_hit_o   (mshr_check_hit_o),
        .ack_i         (mshr_ack),
        .ack_idx_i     (mshr_ack_idx),
        .ack_entry_o   (mshr_ack_entry),
        .empty_o       (mshr_empty),
        .full_o        (mshr_full_o)
    );

    mh_resp_decode i_resp_decode (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_last_i  (mem_resp_last_i),
        .mem_resp_error_i (mem_resp_error_i),
        .mem_resp_id_i    (mem_resp_id_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .resp             (resp_if.producer)
    );

    mh_refill_execute i_refill_execute (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .resp                (resp_if.consumer),
        .refill_req_ready_i  (refill_req_ready_i),
        .refill_req_valid_o  (refill_req_valid_o),
        .mshr_ack_o          (mshr_ack),
        .mshr_ack_idx_o      (mshr_ack_idx),
        .mshr_ack_entry_i    (mshr_ack_entry),
        .refill_write_data_o (refill_write_data_o),
        .refill_write_dir_o  (refill_write_dir_o),
        .refill_set_o        (refill_set_o),
        .refill_word_o       (refill_word_o),
        .refill_data_o       (refill_data_o),
        .refill_nline_o      (refill_nline_o),
        .busy_o              (refill_busy_o),
        .core_rsp_valid_o    (core_rsp_valid_o),
        .core_rsp_o          (core_rsp)
    );

endmodule

/* mh_refill_execute.sv */
`timescale 1ns/100ps

`include "mh_params.svh"

module mh_refill_execute
    import mh_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    mh_resp_if.consumer    resp,

    input  logic           refill_req_ready_i,
    output logic           refill_req_valid_o,

    output logic           mshr_ack_o,
    output mh_mshr_idx_t   mshr_ack_idx_o,
    input  mh_mshr_entry_t mshr_ack_entry_i,

    output logic           refill_write_data_o,
    output logic           refill_write_dir_o,
    output mh_set_t        refill_set_o,
    output mh_word_idx_t   refill_word_o,
    output mh_word_t       refill_data_o,
    output mh_nline_t      refill_nline_o,
    output logic           busy_o,

    output logic           core_rsp_valid_o,
    output mh_core_rsp_t   core_rsp_o
);

    mh_refill_state_e state_q, state_d;
    mh_word_idx_t     cnt_q, cnt_d;
    mh_mshr_entry_t   entry_q;
    logic             last_word;
    logic             rsp_push;
    mh_core_rsp_t     rsp_wdata;

    // Ask the cache for the refill port whenever a full line is buffered
    assign refill_req_valid_o = (state_q == REFILL_IDLE) & resp.meta_valid;
    assign mshr_ack_o         = refill_req_valid_o & refill_req_ready_i;
    assign mshr_ack_idx_o     = resp.meta.id;

    assign busy_o    = (state_q != REFILL_IDLE);
    assign last_word = (cnt_q == mh_word_idx_t'(`MH_CL_WORDS - 1));

    assign refill_set_o   = entry_q.set;
    assign refill_nline_o = {entry_q.tag, entry_q.set};
    assign refill_word_o  = cnt_q;
    assign refill_data_o  = resp.data;

    always_comb begin
        state_d             = state_q;
        cnt_d               = cnt_q;
        refill_write_data_o = 1'b0;
        refill_write_dir_o  = 1'b0;
        resp.data_pop       = 1'b0;
        resp.meta_pop       = 1'b0;
        case (state_q)
            REFILL_IDLE: begin
                if (mshr_ack_o) begin
                    cnt_d   = '0;
                    state_d = REFILL_WRITE;
                end
            end
            REFILL_WRITE: begin
                // An erroneous line is drained but never written
                refill_write_data_o = ~resp.meta.error;
                resp.data_pop       = 1'b1;
                cnt_d               = cnt_q + 1'b1;
                if (last_word) begin
                    refill_write_dir_o = ~resp.meta.error;
                    resp.meta_pop      = 1'b1;
                    state_d            = REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    // Core gets the requested word as it passes by, error or not
    assign rsp_push  = (state_q == REFILL_WRITE) & entry_q.need_rsp & (cnt_q == entry_q.word);
    assign rsp_wdata = '{data: resp.data, tid: entry_q.tid, error: resp.meta.error};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= REFILL_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mshr_ack_o) begin
            entry_q <= mshr_ack_entry_i;
        end
    end

    // Result buffer, the core is always ready
    mh_fifo #(
        .DEPTH   (1),
        .data_t  (mh_core_rsp_t)
    ) i_core_rsp_buf (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (rsp_push),
        .wdata_i (rsp_wdata),
        .wok_o   (),
        .r_i     (1'b1),
        .rdata_o (core_rsp_o),
        .rok_o   (core_rsp_valid_o)
    );

endmodule

/* mh_resp_decode.sv */
`timescale 1ns/100ps

`include "mh_params.svh"

module mh_resp_decode
    import mh_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         mem_resp_valid_i,
    input  logic         mem_resp_last_i,
    input  logic         mem_resp_error_i,
    input  mh_mshr_idx_t mem_resp_id_i,
    input  mh_word_t     mem_resp_data_i,
    output logic         mem_resp_ready_o,

    mh_resp_if.producer  resp
);

    logic     meta_w;
    logic     meta_wok;
    logic     data_w;
    logic     data_wok;
    mh_meta_t meta_wdata;

    // A last beat needs room in both FIFOs
    assign mem_resp_ready_o = data_wok & (meta_wok | ~mem_resp_last_i);

    assign data_w     = mem_resp_valid_i & mem_resp_ready_o;
    assign meta_w     = data_w & mem_resp_last_i;
    assign meta_wdata = '{error: mem_resp_error_i, id: mem_resp_id_i};

    mh_fifo #(
        .DEPTH   (`MH_META_DEPTH),
        .data_t  (mh_meta_t)
    ) i_meta_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wdata_i (meta_wdata),
        .wok_o   (meta_wok),
        .r_i     (resp.meta_pop),
        .rdata_o (resp.meta),
        .rok_o   (resp.meta_valid)
    );

    // Data validity follows from meta_valid, so the data rok is left open
    mh_fifo #(
        .DEPTH   (`MH_DATA_DEPTH),
        .data_t  (mh_word_t)
    ) i_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (data_w),
        .wdata_i (mem_resp_data_i),
        .wok_o   (data_wok),
        .r_i     (resp.data_pop),
        .rdata_o (resp.data),
        .rok_o   ()
    );

endmodule

/* mh_mshr.sv */
`timescale 1ns/100ps

`include "mh_params.svh"

module mh_mshr
    import mh_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           alloc_i,
    input  mh_mshr_entry_t alloc_entry_i,
    output logic           alloc_full_o,

    input  logic           check_i,
    input  mh_nline_t      check_nline_i,
    output logic           check_hit_o,

    input  logic           ack_i,
    input  mh_mshr_idx_t   ack_idx_i,
    output mh_mshr_entry_t ack_entry_o,

    output logic           empty_o,
    output logic           full_o
);

    logic [`MH_MSHR_SETS-1:0] valid_q;
    mh_mshr_entry_t           entry_q [`MH_MSHR_SETS];
    mh_mshr_idx_t             alloc_idx;
    mh_mshr_idx_t             check_idx;
    mh_mshr_entry_t           check_entry;

    // Index comes from the low bits of the line address
    assign alloc_idx = mh_mshr_idx_t'(alloc_entry_i.set);
    assign check_idx = mh_mshr_idx_t'(check_nline_i);

    // Only one miss per index may be pending
    assign alloc_full_o = valid_q[alloc_idx];

    assign check_entry = entry_q[check_idx];
    assign check_hit_o = check_i & valid_q[check_idx] &
                         ({check_entry.tag, check_entry.set} == check_nline_i);

    assign ack_entry_o = entry_q[ack_idx_i];

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (ack_i) begin
                valid_q[ack_idx_i] <= 1'b0;
            end
            if (alloc_i) begin
                valid_q[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q[alloc_idx] <= alloc_entry_i;
        end
    end

endmodule

/* mh_miss_request.sv */
`timescale 1ns/100ps

module mh_miss_request
    import mh_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         mshr_alloc_i,
    input  mh_nline_t    mshr_alloc_nline_i,
    output logic         mshr_alloc_ready_o,
    output logic         alloc_o,

    input  logic         mem_req_ready_i,
    output logic         mem_req_valid_o,
    output mh_addr_t     mem_req_addr_o,
    output mh_mshr_idx_t mem_req_id_o
);

    typedef enum logic {
        MISS_IDLE = 1'b0,
        MISS_SEND = 1'b1
    } miss_state_e;

    miss_state_e state_q, state_d;
    mh_nline_t   nline_q;

    // New misses are taken only while no memory read is outstanding
    assign mshr_alloc_ready_o = (state_q == MISS_IDLE);
    assign alloc_o            = mshr_alloc_i & mshr_alloc_ready_o;
    assign mem_req_valid_o    = (state_q == MISS_SEND);

    // Whole-line read, the id selects the MSHR entry
    assign mem_req_addr_o = {nline_q, {MH_OFFSET_W{1'b0}}};
    assign mem_req_id_o   = mh_mshr_idx_t'(nline_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE: begin
                if (alloc_o) begin
                    state_d = MISS_SEND;
                end
            end
            MISS_SEND: begin
                if (mem_req_ready_i) begin
                    state_d = MISS_IDLE;
                end
            end
            default: begin
                state_d = MISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MISS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_o) begin
            nline_q <= mshr_alloc_nline_i;
        end
    end

endmodule

/* mh_fifo.sv */
`timescale 1ns/100ps

module mh_fifo #(
    parameter int unsigned DEPTH = 2,
    parameter type         data_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  w_i,
    input  data_t wdata_i,
    output logic  wok_o,

    input  logic  r_i,
    output data_t rdata_o,
    output logic  rok_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    data_t            mem_q [DEPTH];
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             push;
    logic             pop;

    assign wok_o   = (cnt_q != CNT_W'(DEPTH));
    assign rok_o   = (cnt_q != '0);
    assign push    = w_i & wok_o;
    assign pop     = r_i & rok_o;
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule

/* mh_resp_if.sv */
`timescale 1ns/100ps

interface mh_resp_if
    import mh_pkg::*;
();

    // Head of the metadata FIFO, valid once a whole line is buffered
    logic     meta_valid;
    mh_meta_t meta;
    // Head of the data FIFO
    mh_word_t data;

    // Pops take effect on the next clock edge
    logic     meta_pop;
    logic     data_pop;

    modport producer (output meta_valid, meta, data, input meta_pop, data_pop);

    modport consumer (input meta_valid, meta, data, output meta_pop, data_pop);

endinterface

/* mh_pkg.sv */
package mh_pkg;

`include "mh_params.svh"

    // Byte offset bits inside a cache line
    localparam int unsigned MH_OFFSET_W = $clog2(`MH_CL_WORDS * `MH_WORD_W / 8);

    typedef logic [`MH_WORD_W-1:0]               mh_word_t;
    typedef logic [`MH_NLINE_W-1:0]              mh_nline_t;
    typedef logic [5:0]                          mh_set_t;
    typedef logic [`MH_NLINE_W-7:0]              mh_tag_t;
    typedef logic [$clog2(`MH_MSHR_SETS)-1:0]    mh_mshr_idx_t;
    typedef logic [$clog2(`MH_CL_WORDS)-1:0]     mh_word_idx_t;
    typedef logic [`MH_TID_W-1:0]                mh_tid_t;
    typedef logic [`MH_NLINE_W+MH_OFFSET_W-1:0]  mh_addr_t;

    typedef struct packed {
        logic         error;
        mh_mshr_idx_t id;
    } mh_meta_t;

    typedef struct packed {
        mh_tag_t      tag;
        mh_set_t      set;
        mh_tid_t      tid;
        mh_word_idx_t word;
        logic         need_rsp;
    } mh_mshr_entry_t;

    typedef struct packed {
        mh_word_t data;
        mh_tid_t  tid;
        logic     error;
    } mh_core_rsp_t;

    typedef enum logic {
        REFILL_IDLE  = 1'b0,
        REFILL_WRITE = 1'b1
    } mh_refill_state_e;

endpackage

/* mh_params.svh */
`ifndef MH_PARAMS_SVH
`define MH_PARAMS_SVH

// Data path geometry
`define MH_WORD_W     32
`define MH_CL_WORDS   4
`define MH_NLINE_W    26

// One MSHR per index, the memory id is the index
`define MH_MSHR_SETS  4

`define MH_TID_W      4

// Response buffering
`define MH_META_DEPTH 2
`define MH_DATA_DEPTH 8

`endif
